// ==== vlog.f ====
+incdir+verif
rtl/mem_geom_pkg.sv
rtl/afi_pkg.sv
rtl/c2p_stage.sv
rtl/write_group_slicer.sv
rtl/read_latency_line.sv
rtl/read_valid_gather.sv
rtl/ddr_io_datapath.sv
verif/tb_ddr_io_datapath.sv

// ==== verif/tb_vectors.svh ====
// Stimulus and expected-value table for the DDR I/O datapath testbench
// Also holds the xorshift generator used for random write data

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam logic [2:0] K_RESET = 3'd0;
localparam logic [2:0] K_WRITE = 3'd1;
localparam logic [2:0] K_READ  = 3'd2;
localparam logic [2:0] K_SKEW  = 3'd3;
localparam logic [2:0] K_FLUSH = 3'd4;

// Marks a row whose strobe must never produce a read valid
localparam logic [7:0] NO_VALID = 8'hFF;

localparam int NUM_ROWS = 12;

typedef group_slots_t [NUM_GROUPS-1:0]         pad_dq_t;
typedef group_mask_t  [NUM_GROUPS-1:0]         pad_dm_t;
typedef logic [NUM_GROUPS-1:0][RATE_RATIO-1:0] pad_en_t;

typedef struct packed {
	logic [2:0]            kind;
	logic                  rand_data;
	afi_data_t             dq;
	afi_mask_t             dm;
	afi_group_en_t         wr_en;
	afi_group_en_t         dqs_en;
	afi_group_en_t         oct_en;
	read_lat_t             lat;
	logic [NUM_GROUPS-1:0] inc_mask;
	logic [1:0]            strobes;
	pad_dq_t               exp_dq;
	pad_dm_t               exp_dm;
	pad_en_t               exp_oe;
	pad_en_t               exp_dqs;
	pad_en_t               exp_oct;
	logic [7:0]            exp_valid;
} row_t;

row_t rows [NUM_ROWS];

function automatic row_t write_row(input logic rnd, input afi_data_t dq, input afi_mask_t dm,
		input afi_group_en_t wr, input afi_group_en_t dqs, input afi_group_en_t oct,
		input pad_dq_t e_dq, input pad_dm_t e_dm, input pad_en_t e_oe,
		input pad_en_t e_dqs, input pad_en_t e_oct);
	row_t r;
	r = '0;
	r.kind = K_WRITE;
	r.rand_data = rnd;
	r.dq = dq;
	r.dm = dm;
	r.wr_en = wr;
	r.dqs_en = dqs;
	r.oct_en = oct;
	r.exp_dq = e_dq;
	r.exp_dm = e_dm;
	r.exp_oe = e_oe;
	r.exp_dqs = e_dqs;
	r.exp_oct = e_oct;
	return r;
endfunction

function automatic row_t read_row(input logic [2:0] kind, input read_lat_t lat,
		input logic [NUM_GROUPS-1:0] inc, input logic [1:0] strobes, input logic [7:0] exp_v);
	row_t r;
	r = '0;
	r.kind = kind;
	r.lat = lat;
	r.inc_mask = inc;
	r.strobes = strobes;
	r.exp_valid = exp_v;
	return r;
endfunction

// Enable bit j lands on group j mod 2, phase j div 2, which swaps bits 1 and 2
// Valid offsets are L + 3, or L + 4 with both groups skewed
task automatic fill_table();
	rows[0]  = read_row(K_RESET, 5'd0, 2'b00, 2'd0, NO_VALID);
	rows[1]  = write_row(1'b0, 64'h7766_5544_3322_1100, 8'hB2, 4'b0010, 4'b0011, 4'b1100,
		64'h7755_3311_6644_2200, 8'hD4, 4'b0100, 4'b0101, 4'b1010);
	rows[2]  = write_row(1'b1, '0, '0, 4'b1011, 4'b0100, 4'b0001,
		'0, '0, 4'b1101, 4'b0010, 4'b0001);
	rows[3]  = write_row(1'b1, '0, '0, 4'b1110, 4'b1001, 4'b0110,
		'0, '0, 4'b1110, 4'b1001, 4'b0110);
	rows[4]  = write_row(1'b1, '0, '0, 4'b0000, 4'b1111, 4'b0000,
		'0, '0, 4'b0000, 4'b1111, 4'b0000);
	rows[5]  = read_row(K_READ, 5'd0, 2'b00, 2'd1, 8'd3);
	rows[6]  = read_row(K_READ, 5'd5, 2'b00, 2'd1, 8'd8);
	rows[7]  = read_row(K_READ, 5'd31, 2'b00, 2'd1, 8'd34);
	rows[8]  = read_row(K_READ, 5'd5, 2'b00, 2'd3, 8'd8);
	rows[9]  = read_row(K_SKEW, 5'd5, 2'b01, 2'd1, NO_VALID);
	rows[10] = read_row(K_SKEW, 5'd5, 2'b10, 2'd1, 8'd9);
	rows[11] = read_row(K_FLUSH, 5'd5, 2'b00, 2'd1, 8'd8);
endtask

function automatic logic [31:0] xorshift32(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

`endif

// ==== verif/tb_ddr_io_datapath.sv ====
// Testbench for the DDR I/O datapath
// Applies a table of write and read-timing rows to the DUT and checks the
// pad-side write outputs and the AFI read valid against hand-derived values

`timescale 1ns/10ps

module tb_ddr_io_datapath
	import mem_geom_pkg::*;
	import afi_pkg::*;
();

	localparam int CLK_HALF_NS    = 20;
	localparam int OBSERVE_CYCLES = 40;

	logic                  pll_afi_clk;
	logic                  reset_n_afi_clk;
	afi_data_t             phy_ddio_dq;
	afi_mask_t             phy_ddio_wrdata_mask;
	afi_group_en_t         phy_ddio_wrdata_en;
	afi_group_en_t         phy_ddio_dqs_en;
	afi_group_en_t         phy_ddio_oct_ena;
	logic                  afi_rdata_en_full;
	read_lat_t             seq_read_latency_counter;
	logic [NUM_GROUPS-1:0] seq_read_increment_vfifo_fr;
	logic                  seq_read_fifo_reset;
	logic [RATE_RATIO-1:0] afi_rdata_valid;

	`include "tb_vectors.svh"

	pad_dq_t     phy_mem_dq_slots;
	pad_dm_t     phy_mem_dm_slots;
	pad_en_t     phy_mem_oe;
	pad_en_t     phy_mem_dqs_en;
	pad_en_t     phy_mem_oct_en;

	// Budget of 40 cycles per row plus some slack for reset and flush rows
	localparam int WATCHDOG_NS = NUM_ROWS * 40 * 40 + 200 * 40;

	logic [31:0] rng;
	int          row_idx;
	int          row_errors;
	int          total_errors;
	int          pass_count;
	int          fail_count;
	pad_dq_t     prev_dq;
	pad_dm_t     prev_dm;
	pad_en_t     prev_oe;
	pad_en_t     prev_dqs;
	pad_en_t     prev_oct;

	ddr_io_datapath #(
		.REGISTER_C2P      (1'b1),
		.EXTRA_VFIFO_SHIFT (1)
	) dut0 (
		.pll_afi_clk                 (pll_afi_clk),
		.reset_n_afi_clk             (reset_n_afi_clk),
		.phy_ddio_dq                 (phy_ddio_dq),
		.phy_ddio_wrdata_mask        (phy_ddio_wrdata_mask),
		.phy_ddio_wrdata_en          (phy_ddio_wrdata_en),
		.phy_ddio_dqs_en             (phy_ddio_dqs_en),
		.phy_ddio_oct_ena            (phy_ddio_oct_ena),
		.phy_mem_dq_slots            (phy_mem_dq_slots),
		.phy_mem_dm_slots            (phy_mem_dm_slots),
		.phy_mem_oe                  (phy_mem_oe),
		.phy_mem_dqs_en              (phy_mem_dqs_en),
		.phy_mem_oct_en              (phy_mem_oct_en),
		.afi_rdata_en_full           (afi_rdata_en_full),
		.seq_read_latency_counter    (seq_read_latency_counter),
		.seq_read_increment_vfifo_fr (seq_read_increment_vfifo_fr),
		.seq_read_fifo_reset         (seq_read_fifo_reset),
		.afi_rdata_valid             (afi_rdata_valid)
	);

	initial begin
		pll_afi_clk = 1'b0;
		forever #(CLK_HALF_NS) pll_afi_clk = ~pll_afi_clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("ERROR: watchdog expired before all rows finished");
		$display("Simulation failed");
		$finish;
	end

	task automatic report_mismatch(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		$display("CHECK FAILED row %0d %s: expected 0x%0h, got 0x%0h at %0t",
			row_idx, name, exp, got, $time);
		row_errors++;
	endtask

	// Field k of the AFI bus belongs to group k mod 2 in slot k div 2
	function automatic pad_dq_t regroup_dq(input afi_data_t dq);
		pad_dq_t r;
		for (int k = 0; k < NUM_SLOTS * NUM_GROUPS; k++) begin
			r[k % NUM_GROUPS][k / NUM_GROUPS] = dq[k*GROUP_DQ_WIDTH +: GROUP_DQ_WIDTH];
		end
		return r;
	endfunction

	function automatic pad_dm_t regroup_dm(input afi_mask_t dm);
		pad_dm_t r;
		for (int k = 0; k < NUM_SLOTS * NUM_GROUPS; k++) begin
			r[k % NUM_GROUPS][k / NUM_GROUPS] = dm[k*GROUP_DM_WIDTH +: GROUP_DM_WIDTH];
		end
		return r;
	endfunction

	function automatic string kind_name(input logic [2:0] kind);
		case (kind)
			K_RESET: return "reset state";
			K_WRITE: return "write regroup";
			K_READ:  return "read valid";
			K_SKEW:  return "group skew";
			default: return "fifo flush";
		endcase
	endfunction

	task automatic check_pad_outputs(input pad_dq_t e_dq, input pad_dm_t e_dm,
			input pad_en_t e_oe, input pad_en_t e_dqs, input pad_en_t e_oct);
		if (phy_mem_dq_slots !== e_dq) report_mismatch("phy_mem_dq_slots", phy_mem_dq_slots, e_dq);
		if (phy_mem_dm_slots !== e_dm) report_mismatch("phy_mem_dm_slots", phy_mem_dm_slots, e_dm);
		if (phy_mem_oe !== e_oe) report_mismatch("phy_mem_oe", phy_mem_oe, e_oe);
		if (phy_mem_dqs_en !== e_dqs) report_mismatch("phy_mem_dqs_en", phy_mem_dqs_en, e_dqs);
		if (phy_mem_oct_en !== e_oct) report_mismatch("phy_mem_oct_en", phy_mem_oct_en, e_oct);
	endtask

	task automatic check_zero_outputs();
		check_pad_outputs('0, '0, '0, '0, '0);
		if (afi_rdata_valid !== '0) begin
			report_mismatch("afi_rdata_valid", afi_rdata_valid, 0);
		end
	endtask

	// The write inputs and the read strobe stay high until release, so only
	// the reset can hold the outputs at zero
	task automatic check_reset_release();
		@(negedge pll_afi_clk);
		check_zero_outputs();
		@(posedge pll_afi_clk);
		reset_n_afi_clk <= 1'b1;
		phy_ddio_dq <= '0;
		phy_ddio_wrdata_mask <= '0;
		phy_ddio_wrdata_en <= '0;
		phy_ddio_dqs_en <= '0;
		phy_ddio_oct_ena <= '0;
		afi_rdata_en_full <= 1'b0;
		@(posedge pll_afi_clk);
		@(negedge pll_afi_clk);
		check_zero_outputs();
		@(posedge pll_afi_clk);
	endtask

	// Outputs must still hold the previous row one cycle in, and the new row after two
	task automatic run_write(input row_t r);
		afi_data_t dq;
		afi_mask_t dm;
		pad_dq_t   e_dq;
		pad_dm_t   e_dm;
		dq = r.dq;
		dm = r.dm;
		e_dq = r.exp_dq;
		e_dm = r.exp_dm;
		if (r.rand_data) begin
			rng = xorshift32(rng);
			dq[31:0] = rng;
			rng = xorshift32(rng);
			dq[63:32] = rng;
			rng = xorshift32(rng);
			dm = rng[7:0];
			e_dq = regroup_dq(dq);
			e_dm = regroup_dm(dm);
		end
		phy_ddio_dq <= dq;
		phy_ddio_wrdata_mask <= dm;
		phy_ddio_wrdata_en <= r.wr_en;
		phy_ddio_dqs_en <= r.dqs_en;
		phy_ddio_oct_ena <= r.oct_en;
		@(posedge pll_afi_clk);
		@(negedge pll_afi_clk);
		check_pad_outputs(prev_dq, prev_dm, prev_oe, prev_dqs, prev_oct);
		@(posedge pll_afi_clk);
		@(negedge pll_afi_clk);
		check_pad_outputs(e_dq, e_dm, r.exp_oe, r.exp_dqs, r.exp_oct);
		prev_dq = e_dq;
		prev_dm = e_dm;
		prev_oe = r.exp_oe;
		prev_dqs = r.exp_dqs;
		prev_oct = r.exp_oct;
		@(posedge pll_afi_clk);
	endtask

	// Cycle 0 is the edge that samples the first strobe
	task automatic read_phase(input int nstr, input int exp_off, input int flush_rel);
		int                    rel;
		logic [RATE_RATIO-1:0] want;
		for (int s = 0; s < nstr; s++) begin
			afi_rdata_en_full <= 1'b1;
			@(posedge pll_afi_clk);
		end
		afi_rdata_en_full <= 1'b0;
		rel = nstr - 1;
		while (rel < OBSERVE_CYCLES) begin
			seq_read_fifo_reset <= (rel == flush_rel);
			@(negedge pll_afi_clk);
			want = (exp_off >= 0 && rel >= exp_off && rel < exp_off + nstr) ? '1 : '0;
			if (afi_rdata_valid !== want) report_mismatch("afi_rdata_valid", afi_rdata_valid, want);
			@(posedge pll_afi_clk);
			rel++;
		end
		seq_read_fifo_reset <= 1'b0;
	endtask

	task automatic run_read(input row_t r);
		int exp_off;
		exp_off = (r.exp_valid == NO_VALID) ? -1 : int'(r.exp_valid);
		seq_read_latency_counter <= r.lat;
		seq_read_increment_vfifo_fr <= r.inc_mask;
		@(posedge pll_afi_clk);
		seq_read_increment_vfifo_fr <= '0;
		if (r.kind == K_FLUSH) begin
			// The flush lands while the first strobe sits in the latency line
			read_phase(1, -1, 2);
		end
		read_phase(int'(r.strobes), exp_off, -1);
	endtask

	initial begin
		reset_n_afi_clk = 1'b0;
		phy_ddio_dq = '1;
		phy_ddio_wrdata_mask = '1;
		phy_ddio_wrdata_en = '1;
		phy_ddio_dqs_en = '1;
		phy_ddio_oct_ena = '1;
		afi_rdata_en_full = 1'b1;
		seq_read_latency_counter = '0;
		seq_read_increment_vfifo_fr = '0;
		seq_read_fifo_reset = 1'b0;
		rng = 32'd23;
		total_errors = 0;
		pass_count = 0;
		fail_count = 0;
		prev_dq = '0;
		prev_dm = '0;
		prev_oe = '0;
		prev_dqs = '0;
		prev_oct = '0;
		fill_table();
		repeat (3) @(posedge pll_afi_clk);
		for (int i = 0; i < NUM_ROWS; i++) begin
			row_idx = i;
			row_errors = 0;
			if (rows[i].kind == K_RESET) begin
				check_reset_release();
			end else if (rows[i].kind == K_WRITE) begin
				run_write(rows[i]);
			end else begin
				run_read(rows[i]);
			end
			total_errors += row_errors;
			if (row_errors == 0) begin
				pass_count++;
				$display("Row %0d %s: PASS", i, kind_name(rows[i].kind));
			end else begin
				fail_count++;
				$display("Row %0d %s: FAIL (%0d errors)", i, kind_name(rows[i].kind), row_errors);
			end
		end
		$display("Rows passed: %0d, rows failed: %0d, check errors: %0d",
			pass_count, fail_count, total_errors);
		if (fail_count == 0 && total_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

// ==== rtl/ddr_io_datapath.sv ====
// DDR I/O datapath top level
// Write side registers and regroups the AFI write bus per DQS group, read
// side times the read-data valid against the sequencer's read latency

`timescale 1ns/10ps

module ddr_io_datapath
	import mem_geom_pkg::*;
	import afi_pkg::*;
#(
	parameter bit REGISTER_C2P      = 1'b1,
	parameter int EXTRA_VFIFO_SHIFT = 1
) (
	input  logic                                 pll_afi_clk,
	input  logic                                 reset_n_afi_clk,

	input  afi_data_t                            phy_ddio_dq,
	input  afi_mask_t                            phy_ddio_wrdata_mask,
	input  afi_group_en_t                        phy_ddio_wrdata_en,
	input  afi_group_en_t                        phy_ddio_dqs_en,
	input  afi_group_en_t                        phy_ddio_oct_ena,

	output group_slots_t [NUM_GROUPS-1:0]        phy_mem_dq_slots,
	output group_mask_t  [NUM_GROUPS-1:0]        phy_mem_dm_slots,
	output logic [NUM_GROUPS-1:0][RATE_RATIO-1:0] phy_mem_oe,
	output logic [NUM_GROUPS-1:0][RATE_RATIO-1:0] phy_mem_dqs_en,
	output logic [NUM_GROUPS-1:0][RATE_RATIO-1:0] phy_mem_oct_en,

	input  logic                                 afi_rdata_en_full,
	input  read_lat_t                            seq_read_latency_counter,
	input  logic [NUM_GROUPS-1:0]                seq_read_increment_vfifo_fr,
	input  logic                                 seq_read_fifo_reset,
	output logic [RATE_RATIO-1:0]                afi_rdata_valid
);

	afi_data_t              dq_periph;
	afi_mask_t              dm_periph;
	// Index 0 write enable, 1 strobe enable, 2 OCT enable
	afi_group_en_t [2:0]    en_periph;
	logic                   shifted_en;
	logic [NUM_GROUPS-1:0]  group_valid;

	c2p_stage #(
		.REGISTER_C2P (REGISTER_C2P),
		.payload_t    (afi_data_t)
	) u_c2p_dq (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.d               (phy_ddio_dq),
		.q               (dq_periph)
	);

	c2p_stage #(
		.REGISTER_C2P (REGISTER_C2P),
		.payload_t    (afi_mask_t)
	) u_c2p_dm (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.d               (phy_ddio_wrdata_mask),
		.q               (dm_periph)
	);

	// The three enable buses cross together as one payload
	c2p_stage #(
		.REGISTER_C2P (REGISTER_C2P),
		.payload_t    (afi_group_en_t [2:0])
	) u_c2p_en (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.d               ({phy_ddio_oct_ena, phy_ddio_dqs_en, phy_ddio_wrdata_en}),
		.q               (en_periph)
	);

	write_group_slicer u_slicer (
		.pll_afi_clk     (pll_afi_clk),
		.reset_n_afi_clk (reset_n_afi_clk),
		.afi_dq          (dq_periph),
		.afi_dm          (dm_periph),
		.afi_wr_en       (en_periph[0]),
		.afi_dqs_en      (en_periph[1]),
		.afi_oct_en      (en_periph[2]),
		.mem_dq_slots    (phy_mem_dq_slots),
		.mem_dm_slots    (phy_mem_dm_slots),
		.mem_oe          (phy_mem_oe),
		.mem_dqs_en      (phy_mem_dqs_en),
		.mem_oct_en      (phy_mem_oct_en)
	);

	read_valid_gather #(
		.EXTRA_VFIFO_SHIFT (EXTRA_VFIFO_SHIFT)
	) u_gather (
		.pll_afi_clk       (pll_afi_clk),
		.reset_n_afi_clk   (reset_n_afi_clk),
		.afi_rdata_en_full (afi_rdata_en_full),
		.group_valid       (group_valid),
		.shifted_en        (shifted_en),
		.afi_rdata_valid   (afi_rdata_valid)
	);

	// One latency line per DQS group, each with its own skew strobe
	generate
		for (genvar g = 0; g < NUM_GROUPS; g++) begin : g_group
			read_latency_line u_line (
				.pll_afi_clk     (pll_afi_clk),
				.reset_n_afi_clk (reset_n_afi_clk),
				.rdata_en        (shifted_en),
				.read_latency    (seq_read_latency_counter),
				.inc_skew        (seq_read_increment_vfifo_fr[g]),
				.fifo_reset      (seq_read_fifo_reset),
				.rdata_valid     (group_valid[g])
			);
		end
	endgenerate

endmodule

// ==== rtl/read_valid_gather.sv ====
// Read valid gather
// Adds the extra VFIFO shift to the full read enable and reports AFI read
// valid only once every DQS group has flagged its data as valid

`timescale 1ns/10ps

module read_valid_gather
	import mem_geom_pkg::*;
	import afi_pkg::*;
#(
	parameter int EXTRA_VFIFO_SHIFT = 1
) (
	input  logic                  pll_afi_clk,
	input  logic                  reset_n_afi_clk,
	input  logic                  afi_rdata_en_full,
	input  logic [NUM_GROUPS-1:0] group_valid,
	output logic                  shifted_en,
	output logic [RATE_RATIO-1:0] afi_rdata_valid
);

	generate
		if (EXTRA_VFIFO_SHIFT > 0) begin : g_shift
			logic [EXTRA_VFIFO_SHIFT-1:0] shift_q;

			always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
				if (!reset_n_afi_clk) begin
					shift_q <= '0;
				end else begin
					shift_q[0] <= afi_rdata_en_full;
					for (int i = 1; i < EXTRA_VFIFO_SHIFT; i++) begin
						shift_q[i] <= shift_q[i-1];
					end
				end
			end

			assign shifted_en = shift_q[EXTRA_VFIFO_SHIFT-1];
		end else begin : g_no_shift
			assign shifted_en = afi_rdata_en_full;
		end
	endgenerate

	// All groups must agree, otherwise the beat is not yet valid
	// Both half-rate phases report the same valid
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			afi_rdata_valid <= '0;
		end else begin
			afi_rdata_valid <= {RATE_RATIO{&group_valid}};
		end
	end

	a_valid_known: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		!$isunknown(afi_rdata_valid)
	) else $error("afi_rdata_valid has unknown bits");

endmodule

// ==== rtl/read_latency_line.sv ====
// Read latency line of one DQS group
// Delays the shifted read enable by the sequencer's read latency plus a
// per-group skew cycle, and flags read data as valid at the tap

`timescale 1ns/10ps

module read_latency_line
	import afi_pkg::*;
(
	input  logic      pll_afi_clk,
	input  logic      reset_n_afi_clk,
	input  logic      rdata_en,
	input  read_lat_t read_latency,
	input  logic      inc_skew,
	input  logic      fifo_reset,
	output logic      rdata_valid
);

	// Deep enough for the largest latency plus one skew cycle
	localparam int LINE_DEPTH = 33;

	logic [LINE_DEPTH-1:0] line_q;
	logic                  skew_q;
	logic [5:0]            tap;

	// Tap position, one wider than the latency so that 31 plus skew fits
	assign tap = {1'b0, read_latency} + {5'd0, skew_q};

	// Each increment strobe moves this group by one cycle
	// A second increment brings it back to the base latency
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			skew_q <= 1'b0;
		end else if (fifo_reset) begin
			skew_q <= 1'b0;
		end else if (inc_skew) begin
			skew_q <= ~skew_q;
		end
	end

	// Stage k holds the enable delayed by k + 1 cycles
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			line_q <= '0;
		end else if (fifo_reset) begin
			line_q <= '0;
		end else begin
			line_q[0] <= rdata_en;
			for (int k = 1; k < LINE_DEPTH; k++) begin
				line_q[k] <= line_q[k-1];
			end
		end
	end

	// Registered tap, which adds the final cycle of the group latency
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			rdata_valid <= 1'b0;
		end else if (fifo_reset) begin
			rdata_valid <= 1'b0;
		end else begin
			rdata_valid <= line_q[tap];
		end
	end

	// A latency change with a read in flight would drop or duplicate its valid
	a_latency_stable_in_flight: assert property (
		@(posedge pll_afi_clk) disable iff (!reset_n_afi_clk)
		(|line_q) |-> $stable(read_latency)
	) else $error("read_latency changed while a read enable was in flight");

endmodule

// ==== rtl/write_group_slicer.sv ====
// Write group slicer
// Pulls each DQS group's data, mask and enable phases out of the slot-major
// AFI write buses and registers them at the pad boundary

`timescale 1ns/10ps

module write_group_slicer
	import mem_geom_pkg::*;
	import afi_pkg::*;
(
	input  logic                                 pll_afi_clk,
	input  logic                                 reset_n_afi_clk,
	input  afi_data_t                            afi_dq,
	input  afi_mask_t                            afi_dm,
	input  afi_group_en_t                        afi_wr_en,
	input  afi_group_en_t                        afi_dqs_en,
	input  afi_group_en_t                        afi_oct_en,
	output group_slots_t [NUM_GROUPS-1:0]        mem_dq_slots,
	output group_mask_t  [NUM_GROUPS-1:0]        mem_dm_slots,
	output logic [NUM_GROUPS-1:0][RATE_RATIO-1:0] mem_oe,
	output logic [NUM_GROUPS-1:0][RATE_RATIO-1:0] mem_dqs_en,
	output logic [NUM_GROUPS-1:0][RATE_RATIO-1:0] mem_oct_en
);

	group_slots_t [NUM_GROUPS-1:0]         dq_next;
	group_mask_t  [NUM_GROUPS-1:0]         dm_next;
	logic [NUM_GROUPS-1:0][RATE_RATIO-1:0] oe_next;
	logic [NUM_GROUPS-1:0][RATE_RATIO-1:0] dqs_en_next;
	logic [NUM_GROUPS-1:0][RATE_RATIO-1:0] oct_en_next;

	// The AFI buses are ordered by time slot and then by group, so for
	// two groups the fields run D1_T3, D0_T3, ... D1_T0, D0_T0 from the top
	always_comb begin
		for (int g = 0; g < NUM_GROUPS; g++) begin
			for (int t = 0; t < NUM_SLOTS; t++) begin
				dq_next[g][t] = afi_dq[(t*NUM_GROUPS+g)*GROUP_DQ_WIDTH +: GROUP_DQ_WIDTH];
				dm_next[g][t] = afi_dm[(t*NUM_GROUPS+g)*GROUP_DM_WIDTH +: GROUP_DM_WIDTH];
			end
		end
	end

	// Enables carry one bit per group for each half of the AFI cycle
	always_comb begin
		for (int g = 0; g < NUM_GROUPS; g++) begin
			for (int p = 0; p < RATE_RATIO; p++) begin
				oe_next[g][p]     = afi_wr_en[p*NUM_GROUPS+g];
				dqs_en_next[g][p] = afi_dqs_en[p*NUM_GROUPS+g];
				oct_en_next[g][p] = afi_oct_en[p*NUM_GROUPS+g];
			end
		end
	end

	// Pad-side output registers
	// Cleared at reset so that no strobe or output enable fires before training
	always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
		if (!reset_n_afi_clk) begin
			mem_dq_slots <= '0;
			mem_dm_slots <= '0;
			mem_oe       <= '0;
			mem_dqs_en   <= '0;
			mem_oct_en   <= '0;
		end else begin
			mem_dq_slots <= dq_next;
			mem_dm_slots <= dm_next;
			mem_oe       <= oe_next;
			mem_dqs_en   <= dqs_en_next;
			mem_oct_en   <= oct_en_next;
		end
	end

endmodule

// ==== rtl/c2p_stage.sv ====
// Core-to-periphery stage
// Optionally registers one payload on its way from the core into the I/O
// periphery, or passes it straight through when the stage is disabled

`timescale 1ns/10ps

module c2p_stage #(
	parameter bit REGISTER_C2P = 1'b1,
	parameter type payload_t = logic
) (
	input  logic     pll_afi_clk,
	input  logic     reset_n_afi_clk,
	input  payload_t d,
	output payload_t q
);

	generate
		if (REGISTER_C2P) begin : g_reg
			payload_t d_q;

			// One full AFI cycle of margin for the core-to-periphery crossing
			always_ff @(posedge pll_afi_clk or negedge reset_n_afi_clk) begin
				if (!reset_n_afi_clk) begin
					d_q <= '0;
				end else begin
					d_q <= d;
				end
			end

			assign q = d_q;
		end else begin : g_bypass
			// Core timing is good enough to drive the periphery directly
			assign q = d;
		end
	endgenerate

endmodule

// ==== rtl/afi_pkg.sv ====
// AFI-side definitions of the DDR I/O datapath
// Rate ratio, slot count and the bus types seen by the controller side

package afi_pkg;

	import mem_geom_pkg::*;

	// Half-rate interface, two memory clocks per AFI clock
	localparam int RATE_RATIO = 2;

	// Two data beats per memory clock
	localparam int NUM_SLOTS = 2 * RATE_RATIO;

	// Write data for all groups in one AFI cycle, slot-major then group
	typedef logic [NUM_SLOTS*MEM_DQ_WIDTH-1:0] afi_data_t;

	// Write mask, same ordering as the data
	typedef logic [NUM_SLOTS*NUM_GROUPS*GROUP_DM_WIDTH-1:0] afi_mask_t;

	// One bit per group per half-cycle phase
	// Used for write enable, strobe enable and OCT enable
	typedef logic [RATE_RATIO*NUM_GROUPS-1:0] afi_group_en_t;

	// Read latency set by the sequencer, 0 to 31 AFI cycles
	typedef logic [4:0] read_lat_t;

endpackage

// ==== rtl/mem_geom_pkg.sv ====
// Memory-side geometry of the DDR I/O datapath
// Group counts, per-group widths and the per-group slot types at the pad side

package mem_geom_pkg;

	// Number of DQS groups on the interface
	localparam int NUM_GROUPS = 2;

	// DQ and DM bits carried by one DQS group
	localparam int GROUP_DQ_WIDTH = 8;
	localparam int GROUP_DM_WIDTH = 1;

	// Total DQ pins across all groups
	localparam int MEM_DQ_WIDTH = NUM_GROUPS * GROUP_DQ_WIDTH;

	// Four time slots of one group's write data, slot 0 in the low byte
	typedef logic [3:0][GROUP_DQ_WIDTH-1:0] group_slots_t;

	// Four time slots of one group's write mask
	typedef logic [3:0][GROUP_DM_WIDTH-1:0] group_mask_t;

endpackage
